/* verilog/sramHeadPkg.sv */
// SRAM test head shared definitions
// Byte lane and word widths, payload types and the word that an idle
// bank returns while its bitlines stay precharged high

package sramHeadPkg;

	// ######################################
	// Widths
	// ######################################

	localparam int byteWidth = 8;                     // Bits per byte lane
	localparam int laneCount = 4;                     // Byte lanes per word
	localparam int wordWidth = byteWidth * laneCount; // Bits per bank word
	localparam int laneSelWidth = $clog2(laneCount);

	// ######################################
	// Payload types
	// ######################################

	// One byte lane, as seen on the data pins
	typedef logic [byteWidth-1:0] dataByteT;

	// One bank word
	typedef logic [wordWidth-1:0] dataWordT;

	typedef logic [laneSelWidth-1:0] laneSelT; // Byte lane index
	typedef logic [laneCount-1:0] laneMaskT;   // Write enable per lane

	// ######################################
	// Constants
	// ######################################

	// Bitlines float high when no wordline fires
	localparam dataWordT idleReadWord = '1;

endpackage

/* verilog/bankReqIf.sv */
// Bank request bus
// Carries one registered request from the input stage to the bank.
// The wordline decoder and the data lane decoder each drive their own
// part of the bus, the bank takes all of it

`timescale 1ns/1ps

interface bankReqIf #(
	parameter int addrWidth = 10
);
	import sramHeadPkg::*;

	localparam int wordCount = 1 << addrWidth;

	logic [wordCount-1:0] wordline; // One-hot, all zero when idle
	dataWordT writeWord;            // Input byte placed in its lanes
	laneMaskT laneMask;             // Lanes to write
	logic readEn;
	laneSelT laneSel;               // Lane to return on a read

	modport wordlineSide (
		output wordline
	);

	modport laneSide (
		output writeWord,
		output laneMask,
		output readEn,
		output laneSel
	);

	modport bankSide (
		input wordline,
		input writeWord,
		input laneMask,
		input readEn,
		input laneSel
	);

endinterface

/* verilog/wordlineDecoder.sv */
// Wordline decoder
// Registers the word select as a one-hot wordline. The wordline fires
// only while wlEnable is high and preCharge is low, so precharge and
// wordline access never overlap

`timescale 1ns/1ps

module wordlineDecoder #(
	parameter int addrWidth = 10
) (
	input logic clk,
	input logic rstN,
	input logic [addrWidth-1:0] wordSelect,
	input logic wlEnable,
	input logic preCharge,
	bankReqIf.wordlineSide req
);

	localparam int wordCount = 1 << addrWidth;

	logic [wordCount-1:0] wordlineNext;
	logic wordlineFire;

	// ######################################
	// Decode
	// ######################################

	// Precharge phase holds every wordline low
	assign wordlineFire = wlEnable && !preCharge;

	always_comb begin
		wordlineNext = '0;
		if (wordlineFire) begin
			wordlineNext[wordSelect] = 1'b1;
		end
	end

	// ######################################
	// Register
	// ######################################

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			req.wordline <= '0;
		end else begin
			req.wordline <= wordlineNext; // Zero when gated off
		end
	end

endmodule

/* verilog/dataLaneDecoder.sv */
// Data lane decoder
// Places the input byte into the byte lanes of a bank word and builds
// the write mask for the selected lane. Also registers the read strobe
// and the lane select so they travel with the wordline

`timescale 1ns/1ps

module dataLaneDecoder (
	input logic clk,
	input logic rstN,
	input sramHeadPkg::dataByteT dataIn,
	input sramHeadPkg::laneSelT byteSelect,
	input logic writeEnable,
	input logic readEnable,
	bankReqIf.laneSide req
);
	import sramHeadPkg::*;

	laneMaskT laneMaskNext;

	// One mask bit for the selected lane while writing
	always_comb begin
		laneMaskNext = '0;
		if (writeEnable) begin
			laneMaskNext = laneMaskT'(1) << byteSelect;
		end
	end

	// ######################################
	// Control
	// ######################################

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			req.laneMask <= '0;
			req.readEn <= 1'b0;
		end else begin
			req.laneMask <= laneMaskNext;
			req.readEn <= readEnable;
		end
	end

	// ######################################
	// Payload
	// ######################################

	// Byte copied to every lane and the mask picks the one written
	always_ff @(posedge clk) begin
		req.writeWord <= {laneCount{dataIn}};
		req.laneSel <= byteSelect;
	end

endmodule

/* verilog/sramBank.sv */
// Behavioral SRAM bank
// Holds 2^addrWidth words of 32 bits. The one-hot wordline picks the
// row, masked lanes of that row are written, and a read registers the
// row as it stood before the write. With no wordline active the read
// returns the precharged all ones word

`timescale 1ns/1ps

module sramBank #(
	parameter int addrWidth = 10
) (
	input logic clk,
	input logic rstN,
	bankReqIf.bankSide req,
	output sramHeadPkg::dataWordT readWord,
	output logic readValid,
	output sramHeadPkg::laneSelT readLane
);
	import sramHeadPkg::*;

	localparam int wordCount = 1 << addrWidth;

	dataWordT mem [wordCount];
	logic [addrWidth-1:0] rowIdx;
	logic rowActive;

	// ######################################
	// Wordline encode
	// ######################################

	// ORs the indices of the set bits, which is exact for a one-hot wordline
	always_comb begin
		rowIdx = '0;
		for (int row = 0; row < wordCount; row++) begin
			if (req.wordline[row]) begin
				rowIdx = rowIdx | addrWidth'(row);
			end
		end
	end

	assign rowActive = |req.wordline;

	// ######################################
	// Array write
	// ######################################

	always_ff @(posedge clk) begin
		if (rowActive) begin
			for (int lane = 0; lane < laneCount; lane++) begin
				if (req.laneMask[lane]) begin
					mem[rowIdx][lane*byteWidth +: byteWidth] <=
						req.writeWord[lane*byteWidth +: byteWidth];
				end
			end
		end
	end

	// ######################################
	// Read register
	// ######################################

	// Old row contents as the write above lands on the same edge
	always_ff @(posedge clk) begin
		if (req.readEn) begin
			readWord <= rowActive ? mem[rowIdx] : idleReadWord;
			readLane <= req.laneSel;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			readValid <= 1'b0;
		end else begin
			readValid <= req.readEn;
		end
	end

endmodule

/* verilog/readByteMux.sv */
// Read byte mux
// Picks the selected byte lane of the bank read word and registers it
// onto the 8-bit output pins. The pins hold their last byte between
// reads

`timescale 1ns/1ps

module readByteMux (
	input logic clk,
	input logic rstN,
	input sramHeadPkg::dataWordT readWord,
	input logic readValid,
	input sramHeadPkg::laneSelT readLane,
	output sramHeadPkg::dataByteT dataOut
);
	import sramHeadPkg::*;

	dataByteT laneByte;

	// Lane select
	assign laneByte = readWord[readLane*byteWidth +: byteWidth];

	// ######################################
	// Output pins
	// ######################################

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dataOut <= '0;
		end else if (readValid) begin
			dataOut <= laneByte;
		end
		// Otherwise hold
	end

endmodule

/* verilog/sramHead.sv */
// SRAM test head top level
// Three stage pipeline between the chip pins and one behavioral bank.
// Input stage decodes the wordline and the data lanes, the bank stage
// writes or reads the active row, the output stage drives the selected
// byte onto the pins. Read data shows on dataOut on the third edge,
// counting the edge that samples the request

`timescale 1ns/1ps

module sramHead #(
	parameter int addrWidth = 10 // 1024 wordlines
) (
	input logic clk,
	input logic rstN,
	input sramHeadPkg::dataByteT dataIn,      // Byte to write
	output sramHeadPkg::dataByteT dataOut,    // Byte read back
	input logic [addrWidth-1:0] wordSelect,
	input sramHeadPkg::laneSelT byteSelect,   // Byte within the word
	input logic writeEnable,
	input logic readEnable,
	input logic wlEnable,
	input logic preCharge                     // Bitlines held high
);
	import sramHeadPkg::*;

	dataWordT readWord;
	logic readValid;
	laneSelT readLane;

	bankReqIf #(
		.addrWidth(addrWidth)
	) bankReq ();

	// ######################################
	// Input stage
	// ######################################

	wordlineDecoder #(
		.addrWidth(addrWidth)
	) wordDecoder (
		.clk(clk),
		.rstN(rstN),
		.wordSelect(wordSelect),
		.wlEnable(wlEnable),
		.preCharge(preCharge),
		.req(bankReq.wordlineSide)
	);

	dataLaneDecoder laneDecoder (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.byteSelect(byteSelect),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.req(bankReq.laneSide)
	);

	// ######################################
	// Bank stage
	// ######################################

	sramBank #(
		.addrWidth(addrWidth)
	) bank (
		.clk(clk),
		.rstN(rstN),
		.req(bankReq.bankSide),
		.readWord(readWord),
		.readValid(readValid),
		.readLane(readLane)
	);

	// ######################################
	// Output stage
	// ######################################

	readByteMux outMux (
		.clk(clk),
		.rstN(rstN),
		.readWord(readWord),
		.readValid(readValid),
		.readLane(readLane),
		.dataOut(dataOut)
	);

endmodule

/* verif/sramHeadTb.sv */
// SRAM test head testbench
// Drives random and directed requests into the three stage pipeline and
// checks dataOut every cycle against a byte model of a small working set
// of word addresses

`timescale 1ns/1ps

module sramHeadTb;
	import sramHeadPkg::*;

	localparam int addrWidth = 10;
	localparam int slotCount = 16;    // Working set of word addresses
	localparam int randomCycles = 4000;

	logic clk;
	logic rstN;
	dataByteT dataIn;
	dataByteT dataOut;
	logic [addrWidth-1:0] wordSelect;
	laneSelT byteSelect;
	logic writeEnable;
	logic readEnable;
	logic wlEnable;
	logic preCharge;

	logic [addrWidth-1:0] wordAddr [slotCount];
	dataByteT modelMem [slotCount][laneCount];
	bit expFlag [$];                  // Read pending per sampled request
	dataByteT expByte [$];
	dataByteT expOut;                 // What the pins should show now

	sramHead #(
		.addrWidth(addrWidth)
	) UUT (
		.clk(clk),
		.rstN(rstN),
		.dataIn(dataIn),
		.dataOut(dataOut),
		.wordSelect(wordSelect),
		.byteSelect(byteSelect),
		.writeEnable(writeEnable),
		.readEnable(readEnable),
		.wlEnable(wlEnable),
		.preCharge(preCharge)
	);

	// ########################################
	// Clock, reset, watchdog
	// ########################################

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		#2 rstN = 1'b1;
	end

	initial begin
		#2ms;
		$display("Simulation ran too long, the stimulus never finished");
		$display("Test failures found");
		$fatal(1, "Watchdog expired");
	end

	// ########################################
	// Checks and model
	// ########################################

	task automatic checkEqual(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] time %0t signal %s expected %h actual %h",
				$time, name, expected, actual);
			$display("Test failures found");
			$fatal(1, "Stopping on first error");
		end
	endtask

	// Drive one request, let it be sampled, update the model, check the pins
	task automatic issueRequest(input int slot, input laneSelT lane, input dataByteT data,
		input logic we, input logic re, input logic wl, input logic pc);
		logic fires;
		dataByteT oldByte;
		bit flag;
		dataByteT value;
		wordSelect = wordAddr[slot];
		byteSelect = lane;
		dataIn = data;
		writeEnable = we;
		readEnable = re;
		wlEnable = wl;
		preCharge = pc;
		@(posedge clk);
		#1;
		fires = wl && !pc;
		oldByte = fires ? modelMem[slot][lane] : 8'hFF; // Precharged bitlines
		expFlag.push_back(re);
		expByte.push_back(oldByte);
		if (fires && we) begin
			modelMem[slot][lane] = data;
		end
		// Front entry reaches the pins on its third edge
		if (expFlag.size() == 3) begin
			flag = expFlag.pop_front();
			value = expByte.pop_front();
			if (flag) begin
				expOut = value;
			end
		end
		checkEqual("dataOut", expOut, dataOut);
		#1;
	endtask

	task automatic idleCycles(input int count);
		for (int i = 0; i < count; i++) begin
			issueRequest(0, '0, '0, 1'b0, 1'b0, 1'b1, 1'b0);
		end
	endtask

	// ########################################
	// Stimulus
	// ########################################

	initial begin
		int waitCount;
		int slot;
		bit isUnique;
		laneSelT lane;
		dataByteT data;
		void'($urandom(32'hf8b3));
		dataIn = '0;
		wordSelect = '0;
		byteSelect = '0;
		writeEnable = 1'b0;
		readEnable = 1'b0;
		wlEnable = 1'b0;
		preCharge = 1'b1;
		expOut = '0;
		// Distinct random word addresses
		for (int s = 0; s < slotCount; s++) begin
			do begin
				wordAddr[s] = addrWidth'($urandom());
				isUnique = 1'b1;
				for (int k = 0; k < s; k++) begin
					if (wordAddr[k] == wordAddr[s]) begin
						isUnique = 1'b0;
					end
				end
			end while (!isUnique);
		end
		waitCount = 0;
		while (rstN !== 1'b1) begin
			@(posedge clk);
			#1;
			waitCount++;
			if (waitCount > 20) begin
				$display("Reset never completed, rstN stayed low");
				$display("Test failures found");
				$fatal(1, "Reset wait timed out");
			end
		end
		#1;
		checkEqual("dataOut", '0, dataOut);

		for (int s = 0; s < slotCount; s++) begin // Pre-fill every lane
			for (int l = 0; l < laneCount; l++) begin
				issueRequest(s, laneSelT'(l), dataByteT'($urandom()), 1'b1, 1'b0, 1'b1, 1'b0);
			end
		end

		// Write then read back the same lane
		for (int i = 0; i < 16; i++) begin
			slot = $urandom_range(slotCount - 1);
			lane = laneSelT'($urandom());
			data = dataByteT'($urandom());
			issueRequest(slot, lane, data, 1'b1, 1'b0, 1'b1, 1'b0);
			issueRequest(slot, lane, '0, 1'b0, 1'b1, 1'b1, 1'b0);
			idleCycles(2);
			checkEqual("dataOut", data, dataOut);
			idleCycles(3);                           // Pins hold between reads
			checkEqual("dataOut", data, dataOut);
		end

		// Neighbour lanes untouched by a single lane write
		for (int i = 0; i < 8; i++) begin
			slot = $urandom_range(slotCount - 1);
			issueRequest(slot, laneSelT'($urandom()), dataByteT'($urandom()),
				1'b1, 1'b0, 1'b1, 1'b0);
			for (int l = 0; l < laneCount; l++) begin
				issueRequest(slot, laneSelT'(l), '0, 1'b0, 1'b1, 1'b1, 1'b0);
			end
			idleCycles(2);
		end

		// Gated wordline drops writes and reads see 8'hFF
		for (int i = 0; i < 8; i++) begin
			slot = $urandom_range(slotCount - 1);
			lane = laneSelT'($urandom());
			issueRequest(slot, lane, dataByteT'($urandom()), 1'b1, 1'b0, 1'b1, 1'b1);
			issueRequest(slot, lane, dataByteT'($urandom()), 1'b1, 1'b0, 1'b0, 1'b0);
			issueRequest(slot, lane, '0, 1'b0, 1'b1, 1'b1, 1'b1);
			idleCycles(2);
			checkEqual("dataOut", 8'hFF, dataOut);
			issueRequest(slot, lane, '0, 1'b0, 1'b1, 1'b1, 1'b0);
			issueRequest(slot, lane, '0, 1'b0, 1'b1, 1'b0, 1'b0);
			idleCycles(2);
		end

		// Random back to back traffic
		for (int i = 0; i < randomCycles; i++) begin
			issueRequest($urandom_range(slotCount - 1), laneSelT'($urandom()),
				dataByteT'($urandom()), 1'($urandom()), 1'($urandom()),
				$urandom_range(7) != 0, $urandom_range(7) == 0);
		end
		idleCycles(3);

		$display("All tests passed!");
		$finish;
	end

endmodule

/* project.f */
verilog/sramHeadPkg.sv
verilog/bankReqIf.sv
verilog/wordlineDecoder.sv
verilog/dataLaneDecoder.sv
verilog/sramBank.sv
verilog/readByteMux.sv
verilog/sramHead.sv
verif/sramHeadTb.sv
